// ==== rv_cfg.svh ====
// rv32i core widths and reset values

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32

// general purpose register file
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// first fetch address
`define RV_RESET_PC 32'h8000_0000

`endif

// ==== rv_pkg.sv ====
// rv32i core shared types

`include "rv_cfg.svh"

package rv_pkg;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read through every format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_u;

    typedef enum logic [3:0] {
        kind_alu_reg,
        kind_alu_imm,
        kind_lui,
        kind_auipc,
        kind_jal,
        kind_jalr,
        kind_branch,
        kind_load,
        kind_store,
        kind_nop    // unknown opcodes end up here
    } op_kind_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef struct packed {
        op_kind_e                 kind;
        alu_op_e                  alu_op;
        logic [2:0]               funct3;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [`RV_REG_IDX_W-1:0] rs2;
        logic [`RV_XLEN-1:0]      imm;
        logic                     writes_rd;
    } decode_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;   // word aligned
        logic [`RV_XLEN-1:0] wdata;
        logic [3:0]          wmask;
        logic                write;  // 1 store, 0 load
    } dmem_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]      pc;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_XLEN-1:0]      wdata;
        logic                     we;
    } retire_t;

endpackage

// ==== rv_decoder.sv ====
// rv32i instruction decoder

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_decoder import rv_pkg::*; (
    input  inst_word_u inst,
    output decode_t    dec
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                has_rd;

    // immediates, sign bit is always inst[31]
    assign imm_i = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};
    assign imm_s = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm31_12, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    always_comb begin
        dec.funct3 = inst.r.funct3;
        dec.rd     = inst.r.rd;
        dec.rs1    = inst.r.rs1;
        dec.rs2    = inst.r.rs2;
        dec.kind   = kind_nop;
        dec.imm    = '0;
        has_rd     = 1'b1;
        case (inst.r.opcode)
            opc_op:     dec.kind = kind_alu_reg;
            opc_op_imm: begin dec.kind = kind_alu_imm; dec.imm = imm_i; end
            opc_lui:    begin dec.kind = kind_lui;     dec.imm = imm_u; end
            opc_auipc:  begin dec.kind = kind_auipc;   dec.imm = imm_u; end
            opc_jal:    begin dec.kind = kind_jal;     dec.imm = imm_j; end
            opc_jalr:   begin dec.kind = kind_jalr;    dec.imm = imm_i; end
            opc_load:   begin dec.kind = kind_load;    dec.imm = imm_i; end
            opc_branch: begin
                dec.kind = kind_branch;
                dec.imm  = imm_b;
                has_rd   = 1'b0;
            end
            opc_store: begin
                dec.kind = kind_store;
                dec.imm  = imm_s;
                has_rd   = 1'b0;
            end
            default: has_rd = 1'b0;   // retires as a no-op
        endcase

        // alu op only matters for the two alu kinds, address math is an add
        dec.alu_op = alu_add;
        if (dec.kind == kind_alu_reg || dec.kind == kind_alu_imm) begin
            case (inst.r.funct3)
                3'b000:  dec.alu_op = (dec.kind == kind_alu_reg && inst.r.funct7[5]) ?
                                      alu_sub : alu_add;
                3'b001:  dec.alu_op = alu_sll;
                3'b010:  dec.alu_op = alu_slt;
                3'b011:  dec.alu_op = alu_sltu;
                3'b100:  dec.alu_op = alu_xor;
                3'b101:  dec.alu_op = inst.r.funct7[5] ? alu_sra : alu_srl; // srai uses bit 30
                3'b110:  dec.alu_op = alu_or;
                default: dec.alu_op = alu_and;
            endcase
        end

        dec.writes_rd = has_rd && (inst.r.rd != '0);
    end

endmodule

// ==== rv_execute.sv ====
// rv32i alu and next pc

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_execute import rv_pkg::*; (
    input  decode_t             dec,
    input  logic [`RV_XLEN-1:0] rs1_val,
    input  logic [`RV_XLEN-1:0] rs2_val,
    input  logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] next_pc,
    output logic                is_mem
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [4:0]          shamt;
    logic                br_eq;
    logic                br_lt;
    logic                br_ltu;
    logic                taken;

    // operand a: pc for pc-relative targets, zero for lui
    always_comb begin
        case (dec.kind)
            kind_auipc, kind_jal, kind_branch: op_a = pc;
            kind_lui:                          op_a = '0;
            default:                           op_a = rs1_val;
        endcase
    end

    assign op_b  = (dec.kind == kind_alu_reg) ? rs2_val : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = `RV_XLEN'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_result = `RV_XLEN'(op_a < op_b);
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $signed(op_a) >>> shamt;
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // branch compares always use the register values
    assign br_eq  = (rs1_val == rs2_val);
    assign br_lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign br_ltu = (rs1_val < rs2_val);

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = br_eq;
            3'b001:  taken = !br_eq;
            3'b100:  taken = br_lt;
            3'b101:  taken = !br_lt;
            3'b110:  taken = br_ltu;
            3'b111:  taken = !br_ltu;
            default: taken = 1'b0;   // reserved encodings fall through
        endcase
    end

    assign pc_plus4 = pc + `RV_XLEN'(4);

    always_comb begin
        case (dec.kind)
            kind_jal:    next_pc = alu_result;
            kind_jalr:   next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
            kind_branch: next_pc = taken ? alu_result : pc_plus4;
            default:     next_pc = pc_plus4;
        endcase
    end

    assign is_mem = (dec.kind == kind_load) || (dec.kind == kind_store);

endmodule

// ==== rv_regfile.sv ====
// rv32i general purpose registers

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_regfile import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  decode_t             dec,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rs1_val,
    output logic [`RV_XLEN-1:0] rs2_val
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && dec.writes_rd) begin   // writes_rd is never set for x0
            regs[dec.rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== rv_lsu.sv ====
// rv32i load/store lane handling

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_lsu import rv_pkg::*; (
    input  decode_t             dec,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] rs2_val,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    output dmem_req_t           dmem_cmd,
    output logic [`RV_XLEN-1:0] load_data
);

    logic [1:0]          byte_off;
    logic [4:0]          lane_shift;
    logic [`RV_XLEN-1:0] lane_data;

    assign byte_off   = addr[1:0];
    assign lane_shift = {byte_off, 3'b000};   // byte offset in bits

    assign dmem_cmd.addr  = {addr[`RV_XLEN-1:2], 2'b00};
    assign dmem_cmd.wdata = rs2_val << lane_shift;
    assign dmem_cmd.write = (dec.kind == kind_store);

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   dmem_cmd.wmask = 4'b0001 << byte_off;   // sb
            2'b01:   dmem_cmd.wmask = 4'b0011 << byte_off;   // sh
            default: dmem_cmd.wmask = 4'b1111;               // sw
        endcase
    end

    // bring the addressed lane down to bit 0
    assign lane_data = mem_rdata >> lane_shift;

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};     // lb
            3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};   // lh
            3'b100:  load_data = {24'b0, lane_data[7:0]};                  // lbu
            3'b101:  load_data = {16'b0, lane_data[15:0]};                 // lhu
            default: load_data = mem_rdata;                                // lw
        endcase
    end

endmodule

// ==== rv_control.sv ====
// rv32i step sequencer

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_control import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_valid,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    output logic                imem_req,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic                dmem_ack,
    output logic                dmem_req,
    input  logic [`RV_XLEN-1:0] next_pc,
    input  logic                is_mem,
    output inst_word_u          inst,
    output logic [`RV_XLEN-1:0] pc,
    output logic                rf_we,
    output logic                retire_valid
);

    typedef enum logic [2:0] {
        st_fetch,
        st_iwait,
        st_exec,
        st_mem,
        st_dwait
    } state_e;

    state_e state;
    logic   retire_fire;

    // last cycle of an instruction, regfile and pc update at its closing edge
    assign retire_fire  = (state == st_exec && !is_mem) || (state == st_dwait && dmem_ack);
    assign rf_we        = retire_fire;
    assign retire_valid = retire_fire;
    assign imem_addr    = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_fetch;
            pc       <= `RV_RESET_PC;
            imem_req <= 1'b0;
            dmem_req <= 1'b0;
        end else begin
            imem_req <= 1'b0;   // both requests are single-cycle pulses
            dmem_req <= 1'b0;
            case (state)
                st_fetch: begin
                    imem_req <= 1'b1;
                    state    <= st_iwait;
                end
                st_iwait: if (imem_valid) state <= st_exec;
                st_exec:  state <= is_mem ? st_mem : st_fetch;
                st_mem: begin
                    dmem_req <= 1'b1;
                    state    <= st_dwait;
                end
                st_dwait: if (dmem_ack) state <= st_fetch;
                default:  state <= st_fetch;
            endcase
            if (retire_fire) pc <= next_pc;
        end
    end

    // instruction register, held until the next fetch returns
    always_ff @(posedge clk) begin
        if (state == st_iwait && imem_valid) begin
            inst <= imem_rdata;
        end
    end

endmodule

// ==== rv_core.sv ====
// rv32i multi-cycle core

`timescale 1ns/1ps

`include "rv_cfg.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    output logic                imem_req,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic                imem_valid,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    output logic                dmem_req,
    output dmem_req_t           dmem_cmd,
    input  logic                dmem_ack,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    output logic                retire_valid,
    output retire_t             retire
);

    inst_word_u          inst;
    decode_t             dec;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic                is_mem;
    logic                rf_we;

    rv_control control_i (
        .clk          (clk),
        .reset        (reset),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .dmem_ack     (dmem_ack),
        .dmem_req     (dmem_req),
        .next_pc      (next_pc),
        .is_mem       (is_mem),
        .inst         (inst),
        .pc           (pc),
        .rf_we        (rf_we),
        .retire_valid (retire_valid)
    );

    rv_decoder decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile regfile_i (
        .clk     (clk),
        .reset   (reset),
        .we      (rf_we),
        .dec     (dec),
        .wdata   (wb_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rv_execute execute_i (
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .pc         (pc),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .is_mem     (is_mem)
    );

    rv_lsu lsu_i (
        .dec       (dec),
        .addr      (alu_result),   // rs1 + imm
        .rs2_val   (rs2_val),
        .mem_rdata (dmem_rdata),
        .dmem_cmd  (dmem_cmd),
        .load_data (load_data)
    );

    // writeback select, jumps link pc+4
    always_comb begin
        case (dec.kind)
            kind_jal, kind_jalr: wb_data = pc + `RV_XLEN'(4);
            kind_load:           wb_data = load_data;
            default:             wb_data = alu_result;
        endcase
    end

    assign retire.pc    = pc;
    assign retire.rd    = dec.rd;
    assign retire.wdata = wb_data;
    assign retire.we    = rf_we && dec.writes_rd;

endmodule

// ==== tb_rv_program.svh ====
// program image and expected retire tables

logic [31:0] prog [$];
retire_t     exp_q [$];
int          exp_group [$];
logic [31:0] mem_check_addr [$];
logic [31:0] mem_check_val [$];

// instruction that retires, rd 0 means no register write
task automatic add_retiring(input int grp, input logic [31:0] word, input logic [4:0] rd,
                            input logic [31:0] value);
    retire_t e;
    e.pc    = base_addr + 32'(4 * prog.size());
    e.rd    = rd;
    e.wdata = value;
    e.we    = (rd != 0);
    exp_q.push_back(e);
    exp_group.push_back(grp);
    prog.push_back(word);
endtask

// jumped over, must never retire
task automatic add_skipped(input logic [31:0] word);
    prog.push_back(word);
endtask

task automatic build_program();
    logic [31:0] poison;
    poison = i_word(opc_imm, 0, 31, 0, 12'd1);
    // alu group, x1 = 5 and x2 = -3 are used by later groups
    add_retiring(0, i_word(opc_imm, 0, 1, 0, 12'd5), 1, 32'd5);
    add_retiring(0, i_word(opc_imm, 0, 2, 0, 12'hffd), 2, 32'hffff_fffd);
    add_retiring(0, r_word(7'h00, 0, 3, 1, 2), 3, 32'd2);             // add
    add_retiring(0, r_word(7'h20, 0, 4, 1, 2), 4, 32'd8);             // sub
    add_retiring(0, i_word(opc_imm, 1, 5, 1, 12'd3), 5, 32'h28);      // slli
    add_retiring(0, i_word(opc_imm, 5, 6, 2, 12'h401), 6, 32'hffff_fffe); // srai
    add_retiring(0, i_word(opc_imm, 5, 7, 2, 12'd28), 7, 32'hf);      // srli
    add_retiring(0, r_word(7'h00, 1, 8, 1, 1), 8, 32'ha0);            // sll
    add_retiring(0, r_word(7'h20, 5, 9, 2, 1), 9, 32'hffff_ffff);     // sra of -3
    add_retiring(0, r_word(7'h00, 2, 10, 2, 1), 10, 32'd1);           // slt
    add_retiring(0, r_word(7'h00, 3, 11, 2, 1), 11, 32'd0);           // sltu
    add_retiring(0, i_word(opc_imm, 2, 12, 2, 12'hffe), 12, 32'd1);   // slti
    add_retiring(0, i_word(opc_imm, 3, 13, 1, 12'hfff), 13, 32'd1);   // sltiu
    add_retiring(0, r_word(7'h00, 4, 14, 1, 2), 14, 32'hffff_fff8);   // xor
    add_retiring(0, r_word(7'h00, 6, 15, 1, 2), 15, 32'hffff_fffd);   // or
    add_retiring(0, r_word(7'h00, 7, 16, 1, 2), 16, 32'd5);           // and
    add_retiring(0, i_word(opc_imm, 4, 17, 1, 12'h7ff), 17, 32'h7fa); // xori
    add_retiring(0, u_word(opc_lui, 18, 20'h12345), 18, 32'h1234_5000);
    add_retiring(0, u_word(opc_auipc, 19, 20'h00001), 19, 32'h8000_1048);
    add_retiring(0, i_word(opc_imm, 6, 20, 18, 12'h678), 20, 32'h1234_5678);
    add_retiring(0, i_word(opc_imm, 7, 21, 20, 12'h0ff), 21, 32'h78);
    // x0 group
    add_retiring(1, i_word(opc_imm, 0, 0, 0, 12'd7), 0, 32'd7);
    add_retiring(1, r_word(7'h00, 0, 22, 0, 1), 22, 32'd5);
    // control flow, taken branches jump over one poison word
    add_retiring(2, b_word(0, 1, 1, 13'd8), 0, 0);   // beq taken
    add_skipped(poison);
    add_retiring(2, b_word(0, 1, 2, 13'd8), 0, 0);
    add_retiring(2, b_word(1, 1, 2, 13'd8), 0, 0);   // bne taken
    add_skipped(poison);
    add_retiring(2, b_word(1, 1, 1, 13'd8), 0, 0);
    add_retiring(2, b_word(4, 2, 1, 13'd8), 0, 0);   // blt taken
    add_skipped(poison);
    add_retiring(2, b_word(4, 1, 2, 13'd8), 0, 0);
    add_retiring(2, b_word(5, 1, 2, 13'd8), 0, 0);   // bge taken
    add_skipped(poison);
    add_retiring(2, b_word(5, 2, 1, 13'd8), 0, 0);
    add_retiring(2, b_word(6, 1, 2, 13'd8), 0, 0);   // bltu taken
    add_skipped(poison);
    add_retiring(2, b_word(6, 2, 1, 13'd8), 0, 0);
    add_retiring(2, b_word(7, 2, 1, 13'd8), 0, 0);   // bgeu taken
    add_skipped(poison);
    add_retiring(2, b_word(7, 1, 2, 13'd8), 0, 0);
    add_retiring(2, j_word(24, 21'd8), 24, 32'h8000_00a8);
    add_skipped(poison);
    add_retiring(2, u_word(opc_auipc, 25, 20'h0), 25, 32'h8000_00ac);
    add_retiring(2, i_word(opc_jalr, 0, 26, 25, 12'd13), 26, 32'h8000_00b4); // odd target
    add_skipped(poison);
    // loads and stores around the data word at 0x8000_0100
    add_retiring(3, u_word(opc_lui, 28, 20'h80000), 28, 32'h8000_0000);
    add_retiring(3, i_word(opc_imm, 0, 28, 28, 12'h100), 28, 32'h8000_0100);
    add_retiring(3, s_word(2, 20, 28, 12'd0), 0, 0);   // sw
    add_retiring(3, s_word(1, 2, 28, 12'd6), 0, 0);    // sh upper half
    add_retiring(3, s_word(0, 1, 28, 12'd9), 0, 0);    // sb lane 1
    add_retiring(3, s_word(0, 2, 28, 12'd11), 0, 0);   // sb lane 3
    add_retiring(3, i_word(opc_load, 2, 29, 28, 12'd0), 29, 32'h1234_5678);
    add_retiring(3, i_word(opc_load, 1, 30, 28, 12'd6), 30, 32'hffff_fffd);
    add_retiring(3, i_word(opc_load, 5, 31, 28, 12'd6), 31, 32'h0000_fffd);
    add_retiring(3, i_word(opc_load, 1, 6, 28, 12'd4), 6, 32'hffff_a4a1);
    add_retiring(3, i_word(opc_load, 0, 7, 28, 12'd11), 7, 32'hffff_fffd);
    add_retiring(3, i_word(opc_load, 4, 8, 28, 12'd11), 8, 32'h0000_00fd);
    add_retiring(3, i_word(opc_load, 4, 9, 28, 12'd9), 9, 32'h0000_0005);
    add_retiring(3, i_word(opc_load, 0, 10, 28, 12'd8), 10, 32'hffff_ffad);
    add_retiring(3, i_word(opc_load, 5, 11, 28, 12'd2), 11, 32'h0000_1234);
    add_skipped(j_word(0, 21'd0));   // parks the core on itself
    // data words after both runs, merged over the fill pattern
    mem_check_addr = '{32'h8000_0100, 32'h8000_0104, 32'h8000_0108, 32'h8000_010c};
    mem_check_val  = '{32'h1234_5678, 32'hfffd_a4a1, 32'hfd5a_05ad, 32'hda5a_a4a9};
endtask

// ==== tb_rv_core.sv ====
// testbench for the rv32i multi-cycle core

`timescale 1ns/1ps

`include "rv_cfg.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam logic [31:0] base_addr  = `RV_RESET_PC;
    localparam int          mem_words  = 128;
    localparam logic [6:0]  opc_reg    = 7'b0110011;
    localparam logic [6:0]  opc_imm    = 7'b0010011;
    localparam logic [6:0]  opc_load   = 7'b0000011;
    localparam logic [6:0]  opc_store  = 7'b0100011;
    localparam logic [6:0]  opc_branch = 7'b1100011;
    localparam logic [6:0]  opc_lui    = 7'b0110111;
    localparam logic [6:0]  opc_auipc  = 7'b0010111;
    localparam logic [6:0]  opc_jal    = 7'b1101111;
    localparam logic [6:0]  opc_jalr   = 7'b1100111;

    logic        clk;
    logic        reset;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [31:0] imem_rdata;
    logic        dmem_req;
    dmem_req_t   dmem_cmd;
    logic        dmem_ack;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] mem [mem_words];   // instruction and data space together
    logic [31:0] lcg_state;
    logic        i_busy;
    logic        d_busy;
    int          i_left;
    int          d_left;
    logic [31:0] i_addr;
    dmem_req_t   d_cmd;
    int          cycles;
    int          cycle_limit;
    int          checks;
    int          errors;
    string       group_name [4] = '{"alu", "x0 register", "control flow", "load/store"};

    // rv32i instruction formats
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs2, rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    `include "tb_rv_program.svh"

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic in_model(input logic [31:0] addr);
        return addr[31:9] == base_addr[31:9];
    endfunction

    // response delay of 1 to 4 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 4) + 1;
    endfunction

    rv_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_ack     (dmem_ack),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) cycles <= 0;
        else cycles <= cycles + 1;
        if (!reset && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles before all instructions retired", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // memory model with one request of each kind in flight
    always @(posedge clk) begin
        imem_valid <= 1'b0;
        dmem_ack   <= 1'b0;
        if (reset) begin
            i_busy <= 1'b0;
            d_busy <= 1'b0;
        end else begin
            if (imem_req) begin
                i_addr <= imem_addr;
                i_left <= next_delay();
                i_busy <= 1'b1;
            end else if (i_busy && i_left > 1) begin
                i_left <= i_left - 1;
            end else if (i_busy) begin
                if (!in_model(i_addr)) begin
                    $display("ERROR at %0d ns: fetch from %h is outside the memory",
                             $time, i_addr);
                    errors++;
                end
                imem_rdata <= mem[i_addr[8:2]];
                imem_valid <= 1'b1;
                i_busy     <= 1'b0;
            end
            if (dmem_req) begin
                d_cmd  <= dmem_cmd;
                d_left <= next_delay();
                d_busy <= 1'b1;
            end else if (d_busy && d_left > 1) begin
                d_left <= d_left - 1;
            end else if (d_busy) begin
                if (!in_model(d_cmd.addr)) begin
                    $display("ERROR at %0d ns: data access at %h is outside the memory",
                             $time, d_cmd.addr);
                    errors++;
                end
                if (d_cmd.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (d_cmd.wmask[b]) begin
                            mem[d_cmd.addr[8:2]][8*b +: 8] <= d_cmd.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    dmem_rdata <= mem[d_cmd.addr[8:2]];
                end
                dmem_ack <= 1'b1;
                d_busy   <= 1'b0;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] <= (i < prog.size()) ? prog[i] : fill_word(base_addr + 32'(4 * i));
        end
    endtask

    // starts on a rising edge or at time zero
    task automatic run_program(input int run_no);
        int      grp_errors;
        retire_t e;
        reset <= 1'b1;
        load_memory();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        grp_errors = errors;
        // nothing retires through the first fetch and its wait
        do begin
            @(negedge clk);
            check("retire_valid", 32'd0, 32'(retire_valid));
            if (imem_req) begin
                check("imem_addr", base_addr, imem_addr);
            end
        end while (!imem_valid);
        foreach (exp_q[i]) begin
            e = exp_q[i];
            do @(negedge clk); while (!retire_valid);
            check("retire.pc", e.pc, retire.pc);
            check("retire.we", 32'(e.we), 32'(retire.we));
            if (e.we) begin
                check("retire.rd", 32'(e.rd), 32'(retire.rd));
                check("retire.wdata", e.wdata, retire.wdata);
            end
            if (i == exp_q.size() - 1 || exp_group[i + 1] != exp_group[i]) begin
                $display("run %0d, %s: %0d errors", run_no, group_name[exp_group[i]],
                         errors - grp_errors);
                grp_errors = errors;
            end
        end
        foreach (mem_check_addr[k]) begin
            check($sformatf("mem[%h]", mem_check_addr[k]), mem_check_val[k],
                  mem[mem_check_addr[k][8:2]]);
        end
        $display("run %0d, memory contents: %0d errors", run_no, errors - grp_errors);
    endtask

    initial begin
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        lcg_state  = 32'h91c8;
        cycles     = 0;
        checks     = 0;
        errors     = 0;
        build_program();
        cycle_limit = exp_q.size() * 12 + 50;
        run_program(1);
        @(posedge clk);
        run_program(2);   // lcg keeps running so the delays differ
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_execute.sv
rv_regfile.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
tb_rv_core.sv
